//--- hdl/sba_config.svh
// Fixed 32-bit bus and data, 5-bit IR, 7-bit DMI address; the IDCODE must keep bit 0 set
`ifndef SBA_CONFIG_SVH
`define SBA_CONFIG_SVH

// Widths
`define SBA_ADDR_W 32
`define SBA_DATA_W 32
`define JTAG_IR_W 5
`define DMI_ADDR_W 7
`define DMI_OP_W 2

// JTAG instructions
`define IR_IDCODE 5'd1
`define IR_DMI 5'd17
`define IR_BYPASS 5'd31

// DMI register map
`define DMI_SBCS 7'd56
`define DMI_SBADDR0 7'd57
`define DMI_SBDATA0 7'd60

// DMI op codes, request and response
`define DMI_OP_NOP 2'd0
`define DMI_OP_READ 2'd1
`define DMI_OP_WRITE 2'd2
`define DMI_RSP_OK 2'd0
`define DMI_RSP_BUSY 2'd3

// SBCS fields
`define SBCS_BUSYERR 22
`define SBCS_BUSY 21
`define SBCS_RDONADDR 20
`define SBCS_ACCESS 17
`define SBCS_AUTOINC 16
`define SBCS_RDONDATA 15
`define SBCS_ERR 12
`define SBA_ACCESS_32 3'd2

`define SBA_IDCODE 32'h1000_5a3d

`endif

//--- hdl/sba_pkg.sv
// Types follow the widths in sba_config.svh; only 32-bit addresses and data are supported
`include "sba_config.svh"

package sba_pkg;

  typedef logic [`SBA_ADDR_W-1:0] sba_addr_t;
  typedef logic [`SBA_DATA_W-1:0] sba_data_t;
  typedef logic [`DMI_ADDR_W-1:0] dmi_addr_t;
  typedef logic [`DMI_OP_W-1:0] dmi_op_t;
  typedef logic [`JTAG_IR_W-1:0] ir_t;

  // IEEE 1149.1 TAP controller states
  typedef enum logic [3:0] {
    TAP_RESET,
    TAP_IDLE,
    SEL_DR,
    CAP_DR,
    SHIFT_DR,
    EXIT1_DR,
    PAUSE_DR,
    EXIT2_DR,
    UPD_DR,
    SEL_IR,
    CAP_IR,
    SHIFT_IR,
    EXIT1_IR,
    PAUSE_IR,
    EXIT2_IR,
    UPD_IR
  } tap_state_e;

  // Bus master, one transfer at a time
  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    RESP
  } axil_state_e;

endpackage

//--- hdl/jtag_tap.sv
// No TRST pin, reset_i forces Test-Logic-Reset; TDO is combinational and unknown IR codes act as BYPASS
`include "sba_config.svh"

module jtag_tap #(
  parameter sba_pkg::sba_data_t IdCode = `SBA_IDCODE
) (
  input  logic jtag_tck,
  input  logic reset_i,
  input  logic tms_i,
  input  logic tdi_i,
  input  logic dmi_tdo_i,
  output logic tdo_o,
  output logic capture_dr_o,
  output logic shift_dr_o,
  output logic update_dr_o
);

  sba_pkg::tap_state_e state_q;
  sba_pkg::tap_state_e state_d;
  sba_pkg::ir_t        ir_q;
  sba_pkg::ir_t        ir_shift_q;
  sba_pkg::sba_data_t  idcode_q;
  logic                bypass_q;
  logic                dmi_sel;

  ////////////////////
  // TAP controller
  ////////////////////

  always_comb begin
    case (state_q)
      sba_pkg::TAP_RESET: state_d = tms_i ? sba_pkg::TAP_RESET : sba_pkg::TAP_IDLE;
      sba_pkg::TAP_IDLE:  state_d = tms_i ? sba_pkg::SEL_DR : sba_pkg::TAP_IDLE;
      sba_pkg::SEL_DR:    state_d = tms_i ? sba_pkg::SEL_IR : sba_pkg::CAP_DR;
      sba_pkg::CAP_DR:    state_d = tms_i ? sba_pkg::EXIT1_DR : sba_pkg::SHIFT_DR;
      sba_pkg::SHIFT_DR:  state_d = tms_i ? sba_pkg::EXIT1_DR : sba_pkg::SHIFT_DR;
      sba_pkg::EXIT1_DR:  state_d = tms_i ? sba_pkg::UPD_DR : sba_pkg::PAUSE_DR;
      sba_pkg::PAUSE_DR:  state_d = tms_i ? sba_pkg::EXIT2_DR : sba_pkg::PAUSE_DR;
      sba_pkg::EXIT2_DR:  state_d = tms_i ? sba_pkg::UPD_DR : sba_pkg::SHIFT_DR;
      sba_pkg::SEL_IR:    state_d = tms_i ? sba_pkg::TAP_RESET : sba_pkg::CAP_IR;
      sba_pkg::CAP_IR:    state_d = tms_i ? sba_pkg::EXIT1_IR : sba_pkg::SHIFT_IR;
      sba_pkg::SHIFT_IR:  state_d = tms_i ? sba_pkg::EXIT1_IR : sba_pkg::SHIFT_IR;
      sba_pkg::EXIT1_IR:  state_d = tms_i ? sba_pkg::UPD_IR : sba_pkg::PAUSE_IR;
      sba_pkg::PAUSE_IR:  state_d = tms_i ? sba_pkg::EXIT2_IR : sba_pkg::PAUSE_IR;
      sba_pkg::EXIT2_IR:  state_d = tms_i ? sba_pkg::UPD_IR : sba_pkg::SHIFT_IR;
      // Both update states leave the same way
      default:            state_d = tms_i ? sba_pkg::SEL_DR : sba_pkg::TAP_IDLE;
    endcase
  end

  always_ff @(posedge jtag_tck) begin
    if (reset_i) begin
      state_q <= sba_pkg::TAP_RESET;
      ir_q    <= `IR_IDCODE;
    end else begin
      state_q <= state_d;
      if (state_q == sba_pkg::TAP_RESET) begin
        ir_q <= `IR_IDCODE;
      end else if (state_q == sba_pkg::UPD_IR) begin
        ir_q <= ir_shift_q;
      end
    end
  end

  ////////////////////
  // Shift registers
  ////////////////////

  always_ff @(posedge jtag_tck) begin
    case (state_q)
      // Capture pattern ends in 01 as the standard asks
      sba_pkg::CAP_IR:   ir_shift_q <= {{(`JTAG_IR_W-2){1'b0}}, 2'b01};
      sba_pkg::SHIFT_IR: ir_shift_q <= {tdi_i, ir_shift_q[`JTAG_IR_W-1:1]};
      sba_pkg::CAP_DR: begin
        idcode_q <= IdCode;
        bypass_q <= 1'b0;
      end
      sba_pkg::SHIFT_DR: begin
        idcode_q <= {tdi_i, idcode_q[`SBA_DATA_W-1:1]};
        bypass_q <= tdi_i;
      end
      default: ;
    endcase
  end

  // IR_BYPASS and every unassigned code fall to the bypass bit
  always_comb begin
    if (state_q == sba_pkg::SHIFT_IR) begin
      tdo_o = ir_shift_q[0];
    end else begin
      case (ir_q)
        `IR_IDCODE: tdo_o = idcode_q[0];
        `IR_DMI:    tdo_o = dmi_tdo_i;
        default:    tdo_o = bypass_q;
      endcase
    end
  end

  assign dmi_sel      = (ir_q == `IR_DMI);
  assign capture_dr_o = dmi_sel && (state_q == sba_pkg::CAP_DR);
  assign shift_dr_o   = dmi_sel && (state_q == sba_pkg::SHIFT_DR);
  assign update_dr_o  = dmi_sel && (state_q == sba_pkg::UPD_DR);

endmodule

//--- hdl/dmi_shift.sv
// DMI op 3 is forwarded like any non-nop op; captured status is only ok (0) or busy (3)
`include "sba_config.svh"

module dmi_shift (
  input  logic               jtag_tck,
  input  logic               reset_i,
  input  logic               tdi_i,
  input  logic               capture_dr_i,
  input  logic               shift_dr_i,
  input  logic               update_dr_i,
  input  sba_pkg::sba_data_t dmi_rsp_data_i,
  input  logic               dmi_rsp_busy_i,
  output logic               dmi_tdo_o,
  output logic               dmi_req_valid_o,
  output sba_pkg::dmi_addr_t dmi_req_addr_o,
  output sba_pkg::dmi_op_t   dmi_req_op_o,
  output sba_pkg::sba_data_t dmi_req_data_o
);

  // Layout from LSB: op, data, address
  localparam int unsigned DmiW    = `DMI_ADDR_W + `SBA_DATA_W + `DMI_OP_W;
  localparam int unsigned DataLsb = `DMI_OP_W;
  localparam int unsigned AddrLsb = `DMI_OP_W + `SBA_DATA_W;

  logic [DmiW-1:0]    dr_q;
  sba_pkg::dmi_op_t   upd_op;
  sba_pkg::sba_data_t rsp_data_q;
  logic               rsp_busy_q;

  assign upd_op    = dr_q[`DMI_OP_W-1:0];
  assign dmi_tdo_o = dr_q[0];

  always_ff @(posedge jtag_tck) begin
    if (capture_dr_i) begin
      dr_q <= {dmi_req_addr_o, rsp_data_q, (rsp_busy_q ? `DMI_RSP_BUSY : `DMI_RSP_OK)};
    end else if (shift_dr_i) begin
      dr_q <= {tdi_i, dr_q[DmiW-1:1]};
    end
    if (update_dr_i) begin
      dmi_req_op_o   <= upd_op;
      dmi_req_data_o <= dr_q[DataLsb +: `SBA_DATA_W];
    end
  end

  always_ff @(posedge jtag_tck) begin
    if (reset_i) begin
      dmi_req_valid_o <= 1'b0;
      dmi_req_addr_o  <= '0;
      rsp_data_q      <= '0;
      rsp_busy_q      <= 1'b0;
    end else begin
      // Nop scans only read back the last result
      dmi_req_valid_o <= update_dr_i && (upd_op != `DMI_OP_NOP);
      if (update_dr_i) begin
        dmi_req_addr_o <= dr_q[AddrLsb +: `DMI_ADDR_W];
      end
      // Response arrives in the same cycle as the strobe
      if (dmi_req_valid_o) begin
        rsp_data_q <= dmi_rsp_data_i;
        rsp_busy_q <= dmi_rsp_busy_i;
      end
    end
  end

endmodule

//--- hdl/sba_regs.sv
// 32-bit accesses only; SBADDR0 and SBDATA0 requests while busy are dropped and flag sbbusyerror
`include "sba_config.svh"

module sba_regs (
  input  logic               jtag_tck,
  input  logic               reset_i,
  input  logic               dmi_req_valid_i,
  input  sba_pkg::dmi_addr_t dmi_req_addr_i,
  input  sba_pkg::dmi_op_t   dmi_req_op_i,
  input  sba_pkg::sba_data_t dmi_req_data_i,
  output sba_pkg::sba_data_t dmi_rsp_data_o,
  output logic               dmi_rsp_busy_o,
  output logic               bus_start_o,
  output sba_pkg::sba_addr_t bus_addr_o,
  output sba_pkg::sba_data_t bus_wdata_o,
  output logic               bus_we_o,
  input  logic               bus_done_i,
  input  sba_pkg::sba_data_t bus_rdata_i,
  input  logic               bus_err_i
);

  logic busyerr_q, busy_q, sberr_q;
  logic rdonaddr_q, autoinc_q, rdondata_q;
  logic we_q;
  sba_pkg::sba_addr_t addr_q;
  sba_pkg::sba_data_t data_q;
  sba_pkg::sba_data_t sbcs;
  logic is_rd, is_wr, hit_sbcs, hit_addr, hit_data;
  logic accept, trig_wr, trig_rd, sbcs_wr;

  ////////////////////
  // Request decode
  ////////////////////

  assign is_rd    = dmi_req_valid_i && (dmi_req_op_i == `DMI_OP_READ);
  assign is_wr    = dmi_req_valid_i && (dmi_req_op_i == `DMI_OP_WRITE);
  assign hit_sbcs = (dmi_req_addr_i == `DMI_SBCS);
  assign hit_addr = (dmi_req_addr_i == `DMI_SBADDR0);
  assign hit_data = (dmi_req_addr_i == `DMI_SBDATA0);
  assign sbcs_wr  = is_wr && hit_sbcs;

  assign dmi_rsp_busy_o = dmi_req_valid_i && (hit_addr || hit_data) && busy_q;
  assign accept         = dmi_req_valid_i && (hit_addr || hit_data) && !busy_q;

  // Triggers are ignored until sbbusyerror is cleared
  assign trig_wr = accept && !busyerr_q && is_wr && hit_data;
  assign trig_rd = accept && !busyerr_q &&
                   ((is_wr && hit_addr && rdonaddr_q) || (is_rd && hit_data && rdondata_q));

  always_comb begin
    sbcs = '0;
    sbcs[`SBCS_BUSYERR] = busyerr_q;
    sbcs[`SBCS_BUSY] = busy_q;
    sbcs[`SBCS_RDONADDR] = rdonaddr_q;
    sbcs[`SBCS_ACCESS +: 3] = `SBA_ACCESS_32;
    sbcs[`SBCS_AUTOINC] = autoinc_q;
    sbcs[`SBCS_RDONDATA] = rdondata_q;
    sbcs[`SBCS_ERR] = sberr_q;
    if (hit_sbcs) dmi_rsp_data_o = sbcs;
    else if (hit_addr) dmi_rsp_data_o = addr_q;
    else if (hit_data) dmi_rsp_data_o = data_q;
    else dmi_rsp_data_o = '0;
  end

  ////////////////////
  // Status and start
  ////////////////////

  always_ff @(posedge jtag_tck) begin
    if (reset_i) begin
      busyerr_q   <= 1'b0;
      busy_q      <= 1'b0;
      sberr_q     <= 1'b0;
      rdonaddr_q  <= 1'b0;
      autoinc_q   <= 1'b0;
      rdondata_q  <= 1'b0;
      bus_start_o <= 1'b0;
    end else begin
      bus_start_o <= trig_wr || trig_rd;
      if (trig_wr || trig_rd) begin
        busy_q <= 1'b1;
      end else if (bus_done_i) begin
        busy_q <= 1'b0;
      end
      // Error bits are write-one-to-clear, a new error wins
      if (dmi_rsp_busy_o) begin
        busyerr_q <= 1'b1;
      end else if (sbcs_wr && dmi_req_data_i[`SBCS_BUSYERR]) begin
        busyerr_q <= 1'b0;
      end
      if (bus_done_i && bus_err_i) begin
        sberr_q <= 1'b1;
      end else if (sbcs_wr && dmi_req_data_i[`SBCS_ERR]) begin
        sberr_q <= 1'b0;
      end
      if (sbcs_wr) begin
        rdonaddr_q <= dmi_req_data_i[`SBCS_RDONADDR];
        autoinc_q  <= dmi_req_data_i[`SBCS_AUTOINC];
        rdondata_q <= dmi_req_data_i[`SBCS_RDONDATA];
      end
    end
  end

  // Address and data stay put while busy, so the bus sees them stable
  always_ff @(posedge jtag_tck) begin
    if (trig_wr || trig_rd) begin
      we_q <= trig_wr;
    end
    if (accept && is_wr && hit_addr) begin
      addr_q <= dmi_req_data_i;
    end else if (bus_done_i && autoinc_q) begin
      addr_q <= addr_q + sba_pkg::sba_addr_t'(4);
    end
    if (accept && is_wr && hit_data) begin
      data_q <= dmi_req_data_i;
    end else if (bus_done_i && !we_q) begin
      data_q <= bus_rdata_i;
    end
  end

  assign bus_addr_o  = addr_q;
  assign bus_wdata_o = data_q;
  assign bus_we_o    = we_q;

endmodule

//--- hdl/sba_axil_master.sv
// Single outstanding AXI4-Lite transfer, full-word strobes, any non-OKAY response is an error
module sba_axil_master (
  input  logic               jtag_tck,
  input  logic               reset_i,
  input  logic               bus_start_i,
  input  logic               bus_we_i,
  input  sba_pkg::sba_addr_t bus_addr_i,
  input  sba_pkg::sba_data_t bus_wdata_i,
  output logic               bus_done_o,
  output logic               bus_err_o,
  output sba_pkg::sba_data_t bus_rdata_o,
  output logic               m_awvalid_o,
  input  logic               m_awready_i,
  output sba_pkg::sba_addr_t m_awaddr_o,
  output logic               m_wvalid_o,
  input  logic               m_wready_i,
  output sba_pkg::sba_data_t m_wdata_o,
  output logic [3:0]         m_wstrb_o,
  input  logic               m_bvalid_i,
  output logic               m_bready_o,
  input  logic [1:0]         m_bresp_i,
  output logic               m_arvalid_o,
  input  logic               m_arready_i,
  output sba_pkg::sba_addr_t m_araddr_o,
  input  logic               m_rvalid_i,
  output logic               m_rready_o,
  input  sba_pkg::sba_data_t m_rdata_i,
  input  logic [1:0]         m_rresp_i
);

  sba_pkg::axil_state_e state_q;
  logic               we_q;
  sba_pkg::sba_addr_t addr_q;
  sba_pkg::sba_data_t wdata_q;
  logic               aw_left, w_left, ar_left;
  logic               resp_fire;

  // Channels still waiting for ready after this edge
  assign aw_left   = m_awvalid_o && !m_awready_i;
  assign w_left    = m_wvalid_o && !m_wready_i;
  assign ar_left   = m_arvalid_o && !m_arready_i;
  assign resp_fire = we_q ? (m_bvalid_i && m_bready_o) : (m_rvalid_i && m_rready_o);

  always_ff @(posedge jtag_tck) begin
    if (reset_i) begin
      state_q     <= sba_pkg::IDLE;
      m_awvalid_o <= 1'b0;
      m_wvalid_o  <= 1'b0;
      m_arvalid_o <= 1'b0;
      bus_done_o  <= 1'b0;
      bus_err_o   <= 1'b0;
    end else begin
      bus_done_o <= 1'b0;
      case (state_q)
        sba_pkg::IDLE: begin
          if (bus_start_i) begin
            m_awvalid_o <= bus_we_i;
            m_wvalid_o  <= bus_we_i;
            m_arvalid_o <= !bus_we_i;
            state_q     <= sba_pkg::ADDR;
          end
        end
        sba_pkg::ADDR: begin
          m_awvalid_o <= aw_left;
          m_wvalid_o  <= w_left;
          m_arvalid_o <= ar_left;
          if (!aw_left && !w_left && !ar_left) begin
            state_q <= sba_pkg::RESP;
          end
        end
        sba_pkg::RESP: begin
          if (resp_fire) begin
            bus_done_o <= 1'b1;
            bus_err_o  <= (we_q ? m_bresp_i : m_rresp_i) != 2'b00;
            state_q    <= sba_pkg::IDLE;
          end
        end
        default: state_q <= sba_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge jtag_tck) begin
    if (state_q == sba_pkg::IDLE && bus_start_i) begin
      we_q    <= bus_we_i;
      addr_q  <= bus_addr_i;
      wdata_q <= bus_wdata_i;
    end
    if (!we_q && resp_fire) begin
      bus_rdata_o <= m_rdata_i;
    end
  end

  assign m_awaddr_o = addr_q;
  assign m_araddr_o = addr_q;
  assign m_wdata_o  = wdata_q;
  assign m_wstrb_o  = 4'hf;
  assign m_bready_o = (state_q == sba_pkg::RESP) && we_q;
  assign m_rready_o = (state_q == sba_pkg::RESP) && !we_q;

endmodule

//--- hdl/jtag_sba_top.sv
// Everything runs on jtag_tck, so the AXI4-Lite slave must share that clock; IdCode bit 0 must be 1
`include "sba_config.svh"

module jtag_sba_top #(
  parameter sba_pkg::sba_data_t IdCode = `SBA_IDCODE
) (
  input  logic               jtag_tck,
  input  logic               reset_i,
  input  logic               jtag_tms_i,
  input  logic               jtag_tdi_i,
  output logic               jtag_tdo_o,
  output logic               m_awvalid_o,
  input  logic               m_awready_i,
  output sba_pkg::sba_addr_t m_awaddr_o,
  output logic               m_wvalid_o,
  input  logic               m_wready_i,
  output sba_pkg::sba_data_t m_wdata_o,
  output logic [3:0]         m_wstrb_o,
  input  logic               m_bvalid_i,
  output logic               m_bready_o,
  input  logic [1:0]         m_bresp_i,
  output logic               m_arvalid_o,
  input  logic               m_arready_i,
  output sba_pkg::sba_addr_t m_araddr_o,
  input  logic               m_rvalid_i,
  output logic               m_rready_o,
  input  sba_pkg::sba_data_t m_rdata_i,
  input  logic [1:0]         m_rresp_i
);

  logic               dmi_tdo, capture_dr, shift_dr, update_dr;
  logic               dmi_req_valid, dmi_rsp_busy;
  sba_pkg::dmi_addr_t dmi_req_addr;
  sba_pkg::dmi_op_t   dmi_req_op;
  sba_pkg::sba_data_t dmi_req_data, dmi_rsp_data;
  logic               bus_start, bus_we, bus_done, bus_err;
  sba_pkg::sba_addr_t bus_addr;
  sba_pkg::sba_data_t bus_wdata, bus_rdata;

  jtag_tap #(
    .IdCode(IdCode)
  ) u_tap (
    .jtag_tck    (jtag_tck),
    .reset_i     (reset_i),
    .tms_i       (jtag_tms_i),
    .tdi_i       (jtag_tdi_i),
    .dmi_tdo_i   (dmi_tdo),
    .tdo_o       (jtag_tdo_o),
    .capture_dr_o(capture_dr),
    .shift_dr_o  (shift_dr),
    .update_dr_o (update_dr)
  );

  dmi_shift u_dmi (
    .jtag_tck       (jtag_tck),
    .reset_i        (reset_i),
    .tdi_i          (jtag_tdi_i),
    .capture_dr_i   (capture_dr),
    .shift_dr_i     (shift_dr),
    .update_dr_i    (update_dr),
    .dmi_rsp_data_i (dmi_rsp_data),
    .dmi_rsp_busy_i (dmi_rsp_busy),
    .dmi_tdo_o      (dmi_tdo),
    .dmi_req_valid_o(dmi_req_valid),
    .dmi_req_addr_o (dmi_req_addr),
    .dmi_req_op_o   (dmi_req_op),
    .dmi_req_data_o (dmi_req_data)
  );

  sba_regs u_regs (
    .jtag_tck       (jtag_tck),
    .reset_i        (reset_i),
    .dmi_req_valid_i(dmi_req_valid),
    .dmi_req_addr_i (dmi_req_addr),
    .dmi_req_op_i   (dmi_req_op),
    .dmi_req_data_i (dmi_req_data),
    .dmi_rsp_data_o (dmi_rsp_data),
    .dmi_rsp_busy_o (dmi_rsp_busy),
    .bus_start_o    (bus_start),
    .bus_addr_o     (bus_addr),
    .bus_wdata_o    (bus_wdata),
    .bus_we_o       (bus_we),
    .bus_done_i     (bus_done),
    .bus_rdata_i    (bus_rdata),
    .bus_err_i      (bus_err)
  );

  // AXI4-Lite ports share their names with the top ports
  sba_axil_master u_master (
    .bus_start_i(bus_start),
    .bus_we_i   (bus_we),
    .bus_addr_i (bus_addr),
    .bus_wdata_i(bus_wdata),
    .bus_done_o (bus_done),
    .bus_err_o  (bus_err),
    .bus_rdata_o(bus_rdata),
    .*
  );

endmodule

//--- dv/jtag_sba_checker.sv
// AXI4-Lite protocol checks on the bus master; needs sba_config.svh on the include path
`include "sba_config.svh"

module jtag_sba_checker (
  input logic               jtag_tck,
  input logic               reset_i,
  input logic               m_awvalid_o,
  input logic               m_awready_i,
  input sba_pkg::sba_addr_t m_awaddr_o,
  input logic               m_wvalid_o,
  input logic               m_wready_i,
  input sba_pkg::sba_data_t m_wdata_o,
  input logic               m_arvalid_o,
  input logic               m_arready_i,
  input sba_pkg::sba_addr_t m_araddr_o
);

  // Valid and payload hold until the slave accepts
  aw_hold: assert property (@(posedge jtag_tck) disable iff (reset_i)
    m_awvalid_o && !m_awready_i |=> m_awvalid_o && $stable(m_awaddr_o))
    else $error("AW valid or address changed before ready");
  w_hold: assert property (@(posedge jtag_tck) disable iff (reset_i)
    m_wvalid_o && !m_wready_i |=> m_wvalid_o && $stable(m_wdata_o))
    else $error("W valid or data changed before ready");
  ar_hold: assert property (@(posedge jtag_tck) disable iff (reset_i)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o))
    else $error("AR valid or address changed before ready");

  reset_quiet: assert property (@(posedge jtag_tck)
    reset_i |=> !(m_awvalid_o || m_wvalid_o || m_arvalid_o))
    else $error("Valid high after a reset cycle");

  // One transfer at a time
  no_rd_wr: assert property (@(posedge jtag_tck) disable iff (reset_i)
    !(m_arvalid_o && m_awvalid_o))
    else $error("AR and AW valid together");

endmodule

bind sba_axil_master jtag_sba_checker u_checker (.*);

//--- dv/jtag_sba_tb.sv
// Slave memory covers 256 words; address bit 12 answers SLVERR; TCK period 4
`include "sba_config.svh"

module jtag_sba_tb;

  localparam int unsigned NumAccesses = 600;
  localparam int unsigned TckPeriod   = 4;
  localparam int unsigned Timeout     = NumAccesses * 200 * TckPeriod;

  logic               jtag_tck;
  logic               reset_i;
  logic               tms;
  logic               tdi;
  logic               tdo;
  logic               awvalid, awready, wvalid, wready, bvalid, bready;
  logic               arvalid, arready, rvalid, rready;
  logic [3:0]         wstrb;
  logic [1:0]         bresp, rresp;
  sba_pkg::sba_addr_t awaddr, araddr;
  sba_pkg::sba_data_t wdata, rdata;

  int                 seed = 71269;
  int                 stall_extra;
  sba_pkg::sba_data_t slave_mem [256];
  sba_pkg::sba_data_t model_mem [256];
  sba_pkg::sba_addr_t last_wr_addr, last_rd_addr;
  sba_pkg::sba_data_t last_wr_data;
  sba_pkg::sba_data_t cap_data;
  sba_pkg::dmi_op_t   cap_op;

  jtag_sba_top uut (
    .jtag_tck   (jtag_tck),
    .reset_i    (reset_i),
    .jtag_tms_i (tms),
    .jtag_tdi_i (tdi),
    .jtag_tdo_o (tdo),
    .m_awvalid_o(awvalid),
    .m_awready_i(awready),
    .m_awaddr_o (awaddr),
    .m_wvalid_o (wvalid),
    .m_wready_i (wready),
    .m_wdata_o  (wdata),
    .m_wstrb_o  (wstrb),
    .m_bvalid_i (bvalid),
    .m_bready_o (bready),
    .m_bresp_i  (bresp),
    .m_arvalid_o(arvalid),
    .m_arready_i(arready),
    .m_araddr_o (araddr),
    .m_rvalid_i (rvalid),
    .m_rready_o (rready),
    .m_rdata_i  (rdata),
    .m_rresp_i  (rresp)
  );

  initial begin
    jtag_tck = 1'b0;
    forever #(TckPeriod / 2) jtag_tck = ~jtag_tck;
  end

  initial begin
    #(Timeout);
    $display("Timeout, the tests did not finish within %0d time units", Timeout);
    $display("sim failed");
    $fatal(1);
  end

  // Initial memory contents depend on the byte address
  function automatic sba_pkg::sba_data_t fill_word(int unsigned idx);
    sba_pkg::sba_data_t byte_addr;
    byte_addr = idx * 4;
    return (byte_addr * 32'h9e37_79b1) ^ 32'h5a5a_0000 ^ byte_addr;
  endfunction

  function automatic int rand_below(int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  function automatic sba_pkg::sba_data_t sbcs_exp(logic busyerr, logic busy, logic rdonaddr,
                                                  logic autoinc, logic rdondata, logic err);
    sba_pkg::sba_data_t v;
    v = '0;
    v[`SBCS_BUSYERR] = busyerr;
    v[`SBCS_BUSY] = busy;
    v[`SBCS_RDONADDR] = rdonaddr;
    v[19:17] = 3'd2;
    v[`SBCS_AUTOINC] = autoinc;
    v[`SBCS_RDONDATA] = rdondata;
    v[`SBCS_ERR] = err;
    return v;
  endfunction

  task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, act, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  ////////////////////
  // JTAG driver
  ////////////////////

  // TDO is sampled in the same low phase, before the next rising edge
  task automatic step(input logic tms_v, input logic tdi_v, output logic tdo_v);
    @(negedge jtag_tck);
    tms   = tms_v;
    tdi   = tdi_v;
    tdo_v = tdo;
  endtask

  // From Run-Test/Idle through one DR or IR scan and back to Run-Test/Idle
  task automatic shift_reg(input logic [63:0] din, input int n, input logic is_ir,
                           output logic [63:0] dout);
    logic t;
    dout = '0;
    step(1'b1, 1'b0, t);
    if (is_ir) begin
      step(1'b1, 1'b0, t);
    end
    step(1'b0, 1'b0, t);
    step(1'b0, 1'b0, t);
    for (int i = 0; i < n; i++) begin
      step(i == n - 1, din[i], dout[i]);
    end
    step(1'b1, 1'b0, t);
    step(1'b0, 1'b0, t);
  endtask

  // Captured fields hold the result of the previous request
  task automatic dmi_scan(input sba_pkg::dmi_addr_t addr, input sba_pkg::dmi_op_t op,
                          input sba_pkg::sba_data_t data);
    logic [63:0] din;
    logic [63:0] dout;
    din = {23'd0, addr, data, op};
    shift_reg(din, 41, 1'b0, dout);
    cap_op   = dout[1:0];
    cap_data = dout[33:2];
  endtask

  task automatic dmi_write(input sba_pkg::dmi_addr_t addr, input sba_pkg::sba_data_t data);
    dmi_scan(addr, `DMI_OP_WRITE, data);
    dmi_scan('0, `DMI_OP_NOP, '0);
  endtask

  task automatic dmi_read(input sba_pkg::dmi_addr_t addr, output sba_pkg::sba_data_t data);
    dmi_scan(addr, `DMI_OP_READ, '0);
    dmi_scan('0, `DMI_OP_NOP, '0);
    check("dmi read op", cap_op, `DMI_RSP_OK);
    data = cap_data;
  endtask

  task automatic wait_idle();
    sba_pkg::sba_data_t s;
    do begin
      dmi_read(`DMI_SBCS, s);
    end while (s[`SBCS_BUSY]);
  endtask

  ////////////////////
  // AXI4-Lite slave
  ////////////////////

  task automatic serve_write();
    int d;
    d = rand_below(6) + stall_extra;
    stall_extra = 0;
    repeat (d) @(negedge jtag_tck);
    awready = 1'b1;
    wready = 1'b1;
    last_wr_addr = awaddr;
    last_wr_data = wdata;
    check("wstrb", wstrb, 4'hf);
    @(negedge jtag_tck);
    awready = 1'b0;
    wready = 1'b0;
    if (!last_wr_addr[12]) begin
      slave_mem[last_wr_addr[9:2]] = last_wr_data;
    end
    repeat (rand_below(6)) @(negedge jtag_tck);
    bresp = last_wr_addr[12] ? 2'b10 : 2'b00;
    bvalid = 1'b1;
    while (!bready) @(negedge jtag_tck);
    @(negedge jtag_tck);
    bvalid = 1'b0;
  endtask

  task automatic serve_read();
    repeat (rand_below(6)) @(negedge jtag_tck);
    arready = 1'b1;
    last_rd_addr = araddr;
    @(negedge jtag_tck);
    arready = 1'b0;
    repeat (rand_below(6)) @(negedge jtag_tck);
    rdata = slave_mem[last_rd_addr[9:2]];
    rresp = last_rd_addr[12] ? 2'b10 : 2'b00;
    rvalid = 1'b1;
    while (!rready) @(negedge jtag_tck);
    @(negedge jtag_tck);
    rvalid = 1'b0;
  endtask

  initial begin
    @(negedge reset_i);
    forever begin
      @(negedge jtag_tck);
      if (awvalid && wvalid) begin
        serve_write();
      end else if (arvalid) begin
        serve_read();
      end
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    logic [63:0]        dout;
    logic [63:0]        din;
    logic               t;
    int                 idx;
    int                 n;
    sba_pkg::sba_addr_t addr;
    sba_pkg::sba_data_t data;
    sba_pkg::sba_data_t data2;
    sba_pkg::sba_data_t rd;

    tms = 1'b1;
    tdi = 1'b0;
    awready = 1'b0;
    wready = 1'b0;
    bvalid = 1'b0;
    bresp = 2'b00;
    arready = 1'b0;
    rvalid = 1'b0;
    rresp = 2'b00;
    rdata = '0;
    stall_extra = 0;
    for (int i = 0; i < 256; i++) begin
      slave_mem[i] = fill_word(i);
      model_mem[i] = fill_word(i);
    end
    reset_i = 1'b1;
    repeat (2) @(posedge jtag_tck);
    @(negedge jtag_tck);
    reset_i = 1'b0;

    // IDCODE after reset, then BYPASS
    step(1'b0, 1'b0, t);
    shift_reg('0, 32, 1'b0, dout);
    check("idcode", dout[31:0], `SBA_IDCODE);
    shift_reg(64'd31, 5, 1'b1, dout);
    din = $random(seed);
    shift_reg(din, 17, 1'b0, dout);
    check("bypass tdo", dout[16:0], {din[15:0], 1'b0});
    shift_reg(64'd17, 5, 1'b1, dout);

    // Write then read back through readonaddr
    repeat (6) begin
      idx = rand_below(256);
      addr = idx * 4;
      data = $random(seed);
      dmi_write(`DMI_SBCS, '0);
      dmi_write(`DMI_SBADDR0, addr);
      dmi_write(`DMI_SBDATA0, data);
      check("sbdata0 write op", cap_op, `DMI_RSP_OK);
      wait_idle();
      check("awaddr", last_wr_addr, addr);
      check("wdata", last_wr_data, data);
      model_mem[idx] = data;
      dmi_write(`DMI_SBCS, sbcs_exp(0, 0, 1, 0, 0, 0));
      dmi_write(`DMI_SBADDR0, addr);
      wait_idle();
      check("araddr", last_rd_addr, addr);
      dmi_read(`DMI_SBDATA0, rd);
      check("sbdata0", rd, model_mem[idx]);
      dmi_read(`DMI_SBCS, rd);
      check("sbcs", rd, sbcs_exp(0, 0, 1, 0, 0, 0));
    end

    // Auto-increment with readondata where the first read only primes the data
    repeat (3) begin
      n = 2 + rand_below(7);
      idx = rand_below(240);
      addr = idx * 4;
      dmi_write(`DMI_SBCS, sbcs_exp(0, 0, 0, 1, 1, 0));
      dmi_write(`DMI_SBADDR0, addr);
      dmi_read(`DMI_SBDATA0, rd);
      wait_idle();
      for (int k = 0; k < n; k++) begin
        dmi_read(`DMI_SBDATA0, rd);
        check("sbdata0 autoinc", rd, model_mem[idx + k]);
        wait_idle();
      end
      dmi_read(`DMI_SBADDR0, rd);
      check("sbaddress0", rd, addr + 4 * (n + 1));
    end

    // Busy error while the slave stalls
    idx = rand_below(256);
    addr = idx * 4;
    data = $random(seed);
    data2 = $random(seed);
    dmi_write(`DMI_SBCS, '0);
    dmi_write(`DMI_SBADDR0, addr);
    stall_extra = 1000;
    dmi_write(`DMI_SBDATA0, data);
    check("first write op", cap_op, `DMI_RSP_OK);
    dmi_write(`DMI_SBDATA0, data2);
    check("second write op", cap_op, `DMI_RSP_BUSY);
    dmi_read(`DMI_SBCS, rd);
    check("sbcs.sbbusyerror", rd[`SBCS_BUSYERR], 1'b1);
    wait_idle();
    model_mem[idx] = data;
    dmi_write(`DMI_SBCS, sbcs_exp(1, 0, 0, 0, 0, 0));
    dmi_read(`DMI_SBCS, rd);
    check("sbcs after clear", rd, sbcs_exp(0, 0, 0, 0, 0, 0));
    check("slave memory", slave_mem[idx], model_mem[idx]);

    // Bus error on an address with bit 12 set
    idx = rand_below(256);
    addr = 32'h1000 | (idx * 4);
    dmi_write(`DMI_SBCS, sbcs_exp(0, 0, 1, 0, 0, 0));
    dmi_write(`DMI_SBADDR0, addr);
    wait_idle();
    dmi_read(`DMI_SBCS, rd);
    check("sbcs.sberror", rd, sbcs_exp(0, 0, 1, 0, 0, 1));
    dmi_write(`DMI_SBCS, sbcs_exp(0, 0, 0, 0, 0, 1));
    dmi_read(`DMI_SBCS, rd);
    check("sbcs after clear", rd, sbcs_exp(0, 0, 0, 0, 0, 0));

    $display("sim passed");
    $finish;
  end

endmodule

//--- build.f
+incdir+hdl
hdl/sba_pkg.sv
hdl/jtag_tap.sv
hdl/dmi_shift.sv
hdl/sba_regs.sv
hdl/sba_axil_master.sv
hdl/jtag_sba_top.sv
dv/jtag_sba_checker.sv
dv/jtag_sba_tb.sv

//--- Bender.yml
package:
  name: jtag_sba

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/sba_pkg.sv
      - hdl/jtag_tap.sv
      - hdl/dmi_shift.sv
      - hdl/sba_regs.sv
      - hdl/sba_axil_master.sv
      - hdl/jtag_sba_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/jtag_sba_checker.sv
      - dv/jtag_sba_tb.sv
